// File: Makefile
TOP       ?= tb_exec_cluster
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST := verilog.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

check: run
	@grep -q "All tests passed" $(LOG) && echo "$(TOP): simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    issue_if.sink    issue,
    result_if.source result
);

    hs_state_e           st;
    exec_info_t          info_q;
    write_d_r_t          res_q;
    logic                iss_ack;
    logic                res_req;
    logic                res_valid;
    logic                take;
    logic                load;
    alu_op_e             op;
    logic [LEN_WORD-1:0] a;
    logic [LEN_WORD-1:0] b;
    logic [4:0]          shamt;
    logic [LEN_WORD-1:0] d_rd;

    assign issue.ack  = iss_ack;
    assign result.req = res_req;
    assign result.res = res_q;

    assign a     = info_q.d_rs1;
    assign b     = info_q.d_rs2;
    assign shamt = b[4:0];

    assign take = (st == HS_IDLE) && issue.req;
    assign load = (st == HS_REQ_UP) && !res_valid;

    // func7 bit 5 picks sub and sra
    always_comb begin
        case (info_q.func3)
            3'b000:  op = info_q.func7[5] ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = info_q.func7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD:  d_rd = a + b;
            ALU_SUB:  d_rd = a - b;
            ALU_SLL:  d_rd = a << shamt;
            ALU_SLT:  d_rd = {{(LEN_WORD-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: d_rd = {{(LEN_WORD-1){1'b0}}, a < b};
            ALU_XOR:  d_rd = a ^ b;
            ALU_SRL:  d_rd = a >> shamt;
            ALU_SRA:  d_rd = $unsigned($signed(a) >>> shamt);
            ALU_OR:   d_rd = a | b;
            default:  d_rd = a & b;
        endcase
    end

    // issue ack stays high until the result has been handed over
    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= HS_IDLE;
            iss_ack   <= 1'b0;
            res_req   <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            case (st)
                HS_IDLE: begin
                    if (take) begin
                        iss_ack   <= 1'b1;
                        res_valid <= 1'b0;
                        st        <= HS_REQ_UP;
                    end
                end
                HS_REQ_UP: begin
                    if (!res_valid) begin
                        res_valid <= 1'b1;
                    end else if (!res_req) begin
                        res_req <= 1'b1;
                    end else if (result.ack) begin
                        res_req <= 1'b0;
                        st      <= HS_WAIT_ACK_LOW;
                    end
                end
                HS_WAIT_ACK_LOW: begin
                    if (!result.ack) begin
                        iss_ack <= 1'b0;
                        st      <= HS_DONE;
                    end
                end
                // let the window see ack low before a new entry
                default: st <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            info_q <= issue.info;
        end
        if (load) begin
            res_q <= '{pa_rd: info_q.pa_rd, d_rd: d_rd, contex: info_q.contex};
        end
    end

endmodule

// File: hw/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster import exec_pkg::*; #(
    parameter int NUM_UNITS    = 3,
    parameter int WINDOW_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_req,
    output logic                     in_ack,
    input  logic [LEN_FUNC3-1:0]     in_func3,
    input  logic [LEN_FUNC7-1:0]     in_func7,
    input  logic [LEN_PREG_ADDR-1:0] in_pa_rd,
    input  logic [LEN_WORD-1:0]      in_d_rs1,
    input  logic [LEN_WORD-1:0]      in_d_rs2,
    input  logic [LEN_CONTEXT-1:0]   in_context,
    output logic                     wb_req,
    input  logic                     wb_ack,
    output logic [LEN_PREG_ADDR-1:0] wb_pa_rd,
    output logic [LEN_WORD-1:0]      wb_d_rd,
    output logic [LEN_CONTEXT-1:0]   wb_context
);

    exec_info_t in_info;
    write_d_r_t wb_res;

    issue_if  issue_bus  [NUM_UNITS] ();
    result_if result_bus [NUM_UNITS] ();

    assign in_info = '{
        func3:  in_func3,
        func7:  in_func7,
        pa_rd:  in_pa_rd,
        d_rs1:  in_d_rs1,
        d_rs2:  in_d_rs2,
        contex: in_context
    };

    assign wb_pa_rd   = wb_res.pa_rd;
    assign wb_d_rd    = wb_res.d_rd;
    assign wb_context = wb_res.contex;

    inst_window #(
        .NUM_UNITS    (NUM_UNITS),
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) u_window (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .in_info (in_info),
        .issue   (issue_bus)
    );

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_alu
        alu_unit u_alu (
            .clk    (clk),
            .rst    (rst),
            .issue  (issue_bus[g]),
            .result (result_bus[g])
        );
    end

    wb_arbiter #(
        .NUM_UNITS (NUM_UNITS)
    ) u_arb (
        .clk     (clk),
        .rst     (rst),
        .results (result_bus),
        .wb_req  (wb_req),
        .wb_ack  (wb_ack),
        .wb_res  (wb_res)
    );

endmodule

// File: hw/exec_ifs.sv
`timescale 1ns/1ps

// one issued entry, window -> alu unit
interface issue_if import exec_pkg::*; ();
    logic       req;
    logic       ack;
    exec_info_t info;

    modport source (
        output req,
        output info,
        input  ack
    );

    modport sink (
        input  req,
        input  info,
        output ack
    );
endinterface

// one result, alu unit -> writeback arbiter
interface result_if import exec_pkg::*; ();
    logic       req;
    logic       ack;
    write_d_r_t res;

    modport source (
        output req,
        output res,
        input  ack
    );

    modport sink (
        input  req,
        input  res,
        output ack
    );
endinterface

// File: hw/exec_pkg.sv
package exec_pkg;

    localparam int LEN_WORD      = 32;
    localparam int LEN_PREG_ADDR = 6;
    localparam int LEN_CONTEXT   = 2;
    localparam int LEN_FUNC3     = 3;
    localparam int LEN_FUNC7     = 7;

    // integer alu operations, decoded from func3/func7
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // four-phase handshake progress
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ_UP,
        HS_WAIT_ACK_LOW,
        HS_DONE
    } hs_state_e;

    // window -> exec
    typedef struct packed {
        logic [LEN_FUNC3-1:0]     func3;
        logic [LEN_FUNC7-1:0]     func7;
        logic [LEN_PREG_ADDR-1:0] pa_rd;
        logic [LEN_WORD-1:0]      d_rs1;
        logic [LEN_WORD-1:0]      d_rs2;
        logic [LEN_CONTEXT-1:0]   contex;
    } exec_info_t;

    // exec -> register management
    typedef struct packed {
        logic [LEN_PREG_ADDR-1:0] pa_rd;
        logic [LEN_WORD-1:0]      d_rd;
        logic [LEN_CONTEXT-1:0]   contex;
    } write_d_r_t;

endpackage

// File: hw/inst_window.sv
`timescale 1ns/1ps

module inst_window import exec_pkg::*; #(
    parameter int NUM_UNITS    = 3,
    parameter int WINDOW_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_req,
    output logic       in_ack,
    input  exec_info_t in_info,
    issue_if.source    issue [NUM_UNITS]
);

    localparam int PTR_W = (WINDOW_DEPTH > 1) ? $clog2(WINDOW_DEPTH) : 1;
    localparam int CNT_W = $clog2(WINDOW_DEPTH + 1);

    exec_info_t           buf_mem [WINDOW_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    // slots held until the unit acks, and entries not yet issued
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     queued;
    logic [CNT_W-1:0]     freed;
    hs_state_e            in_st;
    logic                 accept;
    logic                 take;
    hs_state_e            iss_st [NUM_UNITS];
    logic [NUM_UNITS-1:0] iss_req;
    logic [NUM_UNITS-1:0] iss_ack;
    logic [NUM_UNITS-1:0] grant;
    exec_info_t           iss_info [NUM_UNITS];

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_port
        assign issue[g].req  = iss_req[g];
        assign issue[g].info = iss_info[g];
        assign iss_ack[g]    = issue[g].ack;
    end

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(WINDOW_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign accept = (in_st == HS_IDLE) && in_req && (count != CNT_W'(WINDOW_DEPTH));
    assign take   = |grant;

    // oldest entry goes to the lowest idle unit
    always_comb begin
        logic found;
        found = 1'b0;
        grant = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (!found && iss_st[i] == HS_IDLE && queued != '0) begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    always_comb begin
        freed = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (iss_st[i] == HS_REQ_UP && iss_ack[i]) begin
                freed = freed + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_st  <= HS_IDLE;
            in_ack <= 1'b0;
            wr_ptr <= '0;
        end else begin
            case (in_st)
                HS_IDLE: begin
                    if (accept) begin
                        in_ack <= 1'b1;
                        wr_ptr <= ptr_inc(wr_ptr);
                        in_st  <= HS_DONE;
                    end
                end
                HS_DONE: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        in_st  <= HS_IDLE;
                    end
                end
                default: in_st <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_mem[wr_ptr] <= in_info;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count  <= '0;
            queued <= '0;
            rd_ptr <= '0;
        end else begin
            count  <= count + CNT_W'(accept) - freed;
            queued <= queued + CNT_W'(accept) - CNT_W'(take);
            if (take) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    // unit keeps ack high while busy, so idle here means a free unit
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                iss_st[i]  <= HS_IDLE;
                iss_req[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                case (iss_st[i])
                    HS_IDLE: begin
                        if (grant[i]) begin
                            iss_req[i] <= 1'b1;
                            iss_st[i]  <= HS_REQ_UP;
                        end
                    end
                    HS_REQ_UP: begin
                        if (iss_ack[i]) begin
                            iss_req[i] <= 1'b0;
                            iss_st[i]  <= HS_WAIT_ACK_LOW;
                        end
                    end
                    HS_WAIT_ACK_LOW: begin
                        if (!iss_ack[i]) begin
                            iss_st[i] <= HS_IDLE;
                        end
                    end
                    default: iss_st[i] <= HS_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (grant[i]) begin
                iss_info[i] <= buf_mem[rd_ptr];
            end
        end
    end

endmodule

// File: hw/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import exec_pkg::*; #(
    parameter int NUM_UNITS = 3
) (
    input  logic       clk,
    input  logic       rst,
    result_if.sink     results [NUM_UNITS],
    output logic       wb_req,
    input  logic       wb_ack,
    output write_d_r_t wb_res
);

    localparam int IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

    hs_state_e            st;
    logic [IDX_W-1:0]     ptr;
    logic [IDX_W-1:0]     sel;
    logic [IDX_W-1:0]     pick;
    logic                 found;
    logic [NUM_UNITS-1:0] pend;
    logic [NUM_UNITS-1:0] unit_ack;
    write_d_r_t           unit_res [NUM_UNITS];
    write_d_r_t           res_q;

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_port
        assign pend[g]        = results[g].req;
        assign unit_res[g]    = results[g].res;
        assign results[g].ack = unit_ack[g];
    end

    assign wb_res = res_q;

    // search starts just after the last granted unit
    always_comb begin
        int j;
        found = 1'b0;
        pick  = ptr;
        for (int k = 1; k <= NUM_UNITS; k++) begin
            j = (int'(ptr) + k) % NUM_UNITS;
            if (!found && pend[j]) begin
                found = 1'b1;
                pick  = IDX_W'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st       <= HS_IDLE;
            ptr      <= IDX_W'(NUM_UNITS - 1);
            sel      <= '0;
            wb_req   <= 1'b0;
            unit_ack <= '0;
        end else begin
            case (st)
                HS_IDLE: begin
                    if (found) begin
                        sel <= pick;
                        ptr <= pick;
                        st  <= HS_REQ_UP;
                    end
                end
                HS_REQ_UP: begin
                    if (!wb_req) begin
                        wb_req <= 1'b1;
                    end else if (wb_ack) begin
                        wb_req        <= 1'b0;
                        unit_ack[sel] <= 1'b1;
                        st            <= HS_WAIT_ACK_LOW;
                    end
                end
                // both sides must be quiet before the next grant
                HS_WAIT_ACK_LOW: begin
                    if (!wb_ack && !pend[sel]) begin
                        unit_ack[sel] <= 1'b0;
                        st            <= HS_DONE;
                    end
                end
                default: st <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == HS_IDLE && found) begin
            res_q <= unit_res[pick];
        end
    end

endmodule

// File: testbench/exec_cluster_properties.sv
`timescale 1ns/1ps

module exec_cluster_properties import exec_pkg::*; (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_req,
    input logic                     in_ack,
    input logic                     wb_req,
    input logic                     wb_ack,
    input logic [LEN_PREG_ADDR-1:0] wb_pa_rd,
    input logic [LEN_WORD-1:0]      wb_d_rd,
    input logic [LEN_CONTEXT-1:0]   wb_context
);

    // req may only fall once ack has risen
    a_in_req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(in_req) |-> in_ack || $past(in_ack))
        else $error("in_req fell before in_ack rose");

    a_wb_req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(wb_req) |-> wb_ack || $past(wb_ack))
        else $error("wb_req fell before wb_ack rose");

    // in_ack is registered, so it drops one edge after req was seen low
    a_in_ack_order: assert property (@(posedge clk) disable iff (rst)
        $fell(in_ack) |-> !$past(in_req))
        else $error("in_ack fell while in_req was high");

    a_wb_ack_order: assert property (@(posedge clk) disable iff (rst)
        $fell(wb_ack) |-> !wb_req)
        else $error("wb_ack fell while wb_req was high");

    a_wb_stable: assert property (@(posedge clk) disable iff (rst)
        wb_req && $past(wb_req) |-> $stable({wb_pa_rd, wb_d_rd, wb_context}))
        else $error("wb fields changed while wb_req was high");

    a_reset_low: assert property (@(posedge clk)
        rst |=> !in_ack && !wb_req)
        else $error("in_ack or wb_req high during reset");

endmodule

bind exec_cluster exec_cluster_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .wb_req     (wb_req),
    .wb_ack     (wb_ack),
    .wb_pa_rd   (wb_pa_rd),
    .wb_d_rd    (wb_d_rd),
    .wb_context (wb_context)
);

// File: testbench/tb_exec_cluster.sv
`timescale 1ns/1ps

module tb_exec_cluster import exec_pkg::*; ();

    localparam int NUM_UNITS       = 3;
    localparam int WINDOW_DEPTH    = 4;
    localparam int CAPACITY        = NUM_UNITS + WINDOW_DEPTH;
    localparam int N_TESTS         = 24;
    localparam int N_FAST          = 12;
    localparam int RESET_CYCLES    = 16;
    localparam int ROW_CYCLES      = 120;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 + N_TESTS * ROW_CYCLES;

    typedef struct {
        string                    name;
        alu_op_e                  op;
        logic [LEN_WORD-1:0]      rs1;
        logic [LEN_WORD-1:0]      rs2;
        logic [LEN_PREG_ADDR-1:0] pa_rd;
        logic [LEN_CONTEXT-1:0]   ctx;
    } test_row_t;

    logic                     clk;
    logic                     rst;
    logic                     in_req;
    logic                     in_ack;
    logic [LEN_FUNC3-1:0]     in_func3;
    logic [LEN_FUNC7-1:0]     in_func7;
    logic [LEN_PREG_ADDR-1:0] in_pa_rd;
    logic [LEN_WORD-1:0]      in_d_rs1;
    logic [LEN_WORD-1:0]      in_d_rs2;
    logic [LEN_CONTEXT-1:0]   in_context;
    logic                     wb_req;
    logic                     wb_ack;
    logic [LEN_PREG_ADDR-1:0] wb_pa_rd;
    logic [LEN_WORD-1:0]      wb_d_rd;
    logic [LEN_CONTEXT-1:0]   wb_context;

    test_row_t   tbl[$];
    int          tag_to_idx [2**LEN_PREG_ADDR];
    bit          seen [N_TESTS];
    bit          bad [N_TESTS];
    logic [31:0] lfsr = 32'hbe7d_1638;
    int          errors = 0;
    int          accepted = 0;
    int          written = 0;
    int          out_of_order = 0;
    bit          stall_mode = 1'b0;
    bit          saw_full = 1'b0;

    exec_cluster #(
        .NUM_UNITS    (NUM_UNITS),
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_func3   (in_func3),
        .in_func7   (in_func7),
        .in_pa_rd   (in_pa_rd),
        .in_d_rs1   (in_d_rs1),
        .in_d_rs2   (in_d_rs2),
        .in_context (in_context),
        .wb_req     (wb_req),
        .wb_ack     (wb_ack),
        .wb_pa_rd   (wb_pa_rd),
        .wb_d_rd    (wb_d_rd),
        .wb_context (wb_context)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic logic [LEN_FUNC3-1:0] op_func3(input alu_op_e op);
        case (op)
            ALU_ADD, ALU_SUB: return 3'b000;
            ALU_SLL:          return 3'b001;
            ALU_SLT:          return 3'b010;
            ALU_SLTU:         return 3'b011;
            ALU_XOR:          return 3'b100;
            ALU_SRL, ALU_SRA: return 3'b101;
            ALU_OR:           return 3'b110;
            default:          return 3'b111;
        endcase
    endfunction

    function automatic logic [LEN_FUNC7-1:0] op_func7(input alu_op_e op);
        return (op == ALU_SUB || op == ALU_SRA) ? 7'b010_0000 : 7'b000_0000;
    endfunction

    // expected value from the riscv register-register rules
    function automatic logic [LEN_WORD-1:0] ref_result(input alu_op_e op,
            input logic [LEN_WORD-1:0] a, input logic [LEN_WORD-1:0] b);
        logic [4:0]          sh;
        logic [LEN_WORD-1:0] r;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 32'd1;
            ALU_SLL:  r = a << sh;
            // signs differ: the negative one is smaller
            ALU_SLT:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU: r = {31'd0, a < b};
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ALU_OR:   r = a | b;
            default:  r = a & b;
        endcase
        return r;
    endfunction

    function automatic void add_row(input string name, input alu_op_e op,
            input logic [LEN_WORD-1:0] rs1, input logic [LEN_WORD-1:0] rs2,
            input logic [LEN_PREG_ADDR-1:0] pa_rd, input logic [LEN_CONTEXT-1:0] ctx);
        test_row_t r;
        r.name  = name;
        r.op    = op;
        r.rs1   = rs1;
        r.rs2   = rs2;
        r.pa_rd = pa_rd;
        r.ctx   = ctx;
        tag_to_idx[pa_rd] = tbl.size();
        tbl.push_back(r);
    endfunction

    task automatic build_table();
        for (int i = 0; i < 2**LEN_PREG_ADDR; i++) begin
            tag_to_idx[i] = -1;
        end
        // first N_FAST rows run with prompt wb_ack
        add_row("add_basic", ALU_ADD,  32'h0000_0005, 32'h0000_0007, 6'd1,  2'd0);
        add_row("add_wrap",  ALU_ADD,  32'hffff_ffff, 32'h0000_0001, 6'd2,  2'd1);
        add_row("sub_basic", ALU_SUB,  32'h0000_0010, 32'h0000_0003, 6'd3,  2'd2);
        add_row("sub_neg",   ALU_SUB,  32'h0000_0000, 32'h0000_0001, 6'd4,  2'd3);
        add_row("sll_top",   ALU_SLL,  32'h0000_0001, 32'h0000_001f, 6'd5,  2'd0);
        add_row("sll_mask",  ALU_SLL,  32'h0000_00ff, 32'h0000_0024, 6'd6,  2'd1);
        add_row("slt_neg",   ALU_SLT,  32'h8000_0000, 32'h0000_0001, 6'd7,  2'd2);
        add_row("slt_pos",   ALU_SLT,  32'h0000_0001, 32'h8000_0000, 6'd8,  2'd3);
        add_row("sltu_big",  ALU_SLTU, 32'h0000_0001, 32'hffff_ffff, 6'd9,  2'd0);
        add_row("sltu_eq",   ALU_SLTU, 32'h0000_0007, 32'h0000_0007, 6'd10, 2'd1);
        add_row("xor_mix",   ALU_XOR,  32'ha5a5_a5a5, 32'hffff_0000, 6'd11, 2'd2);
        add_row("srl_sign",  ALU_SRL,  32'h8000_0000, 32'h0000_001f, 6'd12, 2'd3);
        // remaining rows run against random wb_ack stalls
        add_row("sra_sign",  ALU_SRA,  32'h8000_0000, 32'h0000_001f, 6'd13, 2'd0);
        add_row("sra_pos",   ALU_SRA,  32'h7fff_fff0, 32'h0000_0004, 6'd14, 2'd1);
        add_row("or_mix",    ALU_OR,   32'h1234_0000, 32'h0000_5678, 6'd15, 2'd2);
        add_row("and_mix",   ALU_AND,  32'hf0f0_f0f0, 32'h3c3c_3c3c, 6'd16, 2'd3);
        add_row("add_max",   ALU_ADD,  32'h7fff_ffff, 32'h0000_0001, 6'd17, 2'd0);
        add_row("sub_min",   ALU_SUB,  32'h8000_0000, 32'h0000_0001, 6'd18, 2'd1);
        add_row("slt_eq",    ALU_SLT,  32'hffff_ffff, 32'hffff_ffff, 6'd19, 2'd2);
        add_row("sltu_zero", ALU_SLTU, 32'h0000_0000, 32'h0000_0001, 6'd20, 2'd3);
        add_row("srl_zero",  ALU_SRL,  32'hdead_beef, 32'h0000_0000, 6'd21, 2'd0);
        add_row("sra_mask",  ALU_SRA,  32'hdead_beef, 32'h0000_0048, 6'd22, 2'd1);
        add_row("or_zero",   ALU_OR,   32'h0000_0000, 32'h0000_0000, 6'd23, 2'd2);
        add_row("and_ones",  ALU_AND,  32'hffff_ffff, 32'h1357_9bdf, 6'd24, 2'd3);
    endtask

    task automatic check_word(input string name, input logic [LEN_WORD-1:0] exp,
            input logic [LEN_WORD-1:0] act, output bit ok);
        ok = (exp === act);
        if (!ok) begin
            errors++;
            $display("FAIL %s: expected d_rd %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_res(input string name, input write_d_r_t exp,
            input write_d_r_t act, output bit ok);
        ok = (exp === act);
        if (!ok) begin
            errors++;
            $display("FAIL %s: expected pa_rd %0d d_rd %h ctx %0d, actual pa_rd %0d d_rd %h ctx %0d",
                     name, exp.pa_rd, exp.d_rd, exp.contex, act.pa_rd, act.d_rd, act.contex);
        end
    endtask

    task automatic send_entry(input int i);
        int waited;
        in_func3   = op_func3(tbl[i].op);
        in_func7   = op_func7(tbl[i].op);
        in_pa_rd   = tbl[i].pa_rd;
        in_d_rs1   = tbl[i].rs1;
        in_d_rs2   = tbl[i].rs2;
        in_context = tbl[i].ctx;
        in_req     = 1'b1;
        waited     = 0;
        do begin
            @(negedge clk);
            waited++;
            // a long wait with everything occupied is the back-pressure case
            if (stall_mode && waited > 8 && accepted - written >= CAPACITY - 1) begin
                saw_full = 1'b1;
            end
        end while (!in_ack);
        accepted++;
        if (accepted - written > CAPACITY) begin
            errors++;
            $display("window accepted %s with %0d entries already outstanding",
                     tbl[i].name, accepted - written - 1);
        end
        in_req = 1'b0;
        do begin
            @(negedge clk);
        end while (in_ack);
    endtask

    initial begin : wb_responder
        write_d_r_t act;
        write_d_r_t exp;
        int         idx;
        int         last_idx;
        bit         ok_word;
        bit         ok_res;
        bit         first_stall;
        last_idx    = -1;
        first_stall = 1'b1;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (wb_req === 1'b1) begin
                act = '{pa_rd: wb_pa_rd, d_rd: wb_d_rd, contex: wb_context};
                written++;
                idx = tag_to_idx[act.pa_rd];
                if (accepted == 0) begin
                    errors++;
                    $display("result with tag %0d appeared before any input", act.pa_rd);
                end
                if (idx < 0) begin
                    errors++;
                    $display("result carries tag %0d that no test used", act.pa_rd);
                end else if (seen[idx]) begin
                    errors++;
                    bad[idx] = 1'b1;
                    $display("tag %0d of %s was written back twice", act.pa_rd, tbl[idx].name);
                end else begin
                    seen[idx] = 1'b1;
                    if (idx < last_idx) begin
                        out_of_order++;
                    end
                    last_idx = idx;
                    exp = '{pa_rd: tbl[idx].pa_rd,
                            d_rd: ref_result(tbl[idx].op, tbl[idx].rs1, tbl[idx].rs2),
                            contex: tbl[idx].ctx};
                    check_word(tbl[idx].name, exp.d_rd, act.d_rd, ok_word);
                    check_res(tbl[idx].name, exp, act, ok_res);
                    if (ok_word && ok_res) begin
                        $display("PASS %s", tbl[idx].name);
                    end else begin
                        bad[idx] = 1'b1;
                    end
                end
                if (stall_mode) begin
                    if (first_stall) begin
                        first_stall = 1'b0;
                        repeat (80) @(negedge clk);
                    end else begin
                        repeat (rand_bits(6)) @(negedge clk);
                    end
                end
                wb_ack = 1'b1;
                do begin
                    @(negedge clk);
                end while (wb_req);
                wb_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin : main
        int n_fail;
        rst        = 1'b1;
        in_req     = 1'b0;
        in_func3   = '0;
        in_func7   = '0;
        in_pa_rd   = '0;
        in_d_rs1   = '0;
        in_d_rs2   = '0;
        in_context = '0;
        wb_ack     = 1'b0;
        n_fail     = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (in_ack !== 1'b0 || wb_req !== 1'b0) begin
            errors++;
            $display("in_ack or wb_req is not low after reset");
        end
        // quiet gap, any result here is flagged by the responder
        repeat (10) @(negedge clk);
        for (int i = 0; i < N_TESTS; i++) begin
            if (i == N_FAST) begin
                stall_mode = 1'b1;
            end
            if (stall_mode) begin
                repeat (rand_bits(2)) @(negedge clk);
            end
            send_entry(i);
        end
        wait (written >= N_TESTS);
        repeat (50) @(negedge clk);
        for (int i = 0; i < N_TESTS; i++) begin
            if (!seen[i]) begin
                errors++;
                bad[i] = 1'b1;
                $display("no result was written back for %s", tbl[i].name);
            end
            if (bad[i]) begin
                n_fail++;
            end
        end
        if (!saw_full) begin
            errors++;
            $display("wb_ack stalls never filled the window and units to hold in_ack low");
        end
        $display("%0d tests: %0d passed, %0d failed, %0d out of order, %0d errors",
                 N_TESTS, N_TESTS - n_fail, n_fail, out_of_order, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hw/exec_pkg.sv
hw/exec_ifs.sv
hw/inst_window.sv
hw/alu_unit.sv
hw/wb_arbiter.sv
hw/exec_cluster.sv
testbench/exec_cluster_properties.sv
testbench/tb_exec_cluster.sv
